// File: dv/eth_pause_tx_tb.sv
// Testbench for the PAUSE transmitter with golden vectors, handshake, frame byte and FCS checks
`timescale 1ns/1ps
`default_nettype none
`include "eth_pause_consts.svh"

module eth_pause_tx_tb;
    import eth_pause_pkg::*;

    localparam int NUM_VECTORS   = 8;
    localparam int NUM_TESTS     = NUM_VECTORS + 2;
    localparam int WATCHDOG_CYC  = NUM_TESTS * 100 + 200;
    localparam int LEAD_LIMIT    = 20;

    logic          clk;
    logic          reset;
    logic          req;
    pause_quanta_t pause_time;
    mac_addr_t     local_mac;
    logic          ack;
    logic [7:0]    tx_data;
    logic          tx_en;
    logic          frame_complete;

    // Golden columns are pause_time, local_mac and the CRC residue after the FCS
    logic [95:0] golden [0:NUM_VECTORS-1];
    logic [7:0]  exp_frame [0:`ETH_FRAME_BYTES-1];
    logic [7:0]  got_frame [0:`ETH_FRAME_BYTES-1];
    integer      seed;
    int          error_count;
    int          failed_tests;
    int          test_start_errs;

    eth_pause_tx_top DUT (
        .clk            (clk),
        .reset          (reset),
        .req            (req),
        .pause_time     (pause_time),
        .local_mac      (local_mac),
        .ack            (ack),
        .tx_data        (tx_data),
        .tx_en          (tx_en),
        .frame_complete (frame_complete)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("Watchdog expired: the run took longer than the tests allow");
        $display("Something failed");
        $finish;
    end

    // Inputs change and outputs are sampled 1 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic report_fail(input string msg);
        error_count++;
        $display("FAILED @%0t: %s", $time, msg);
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) report_fail($sformatf("%s got %02h expected %02h", what, got, exp));
    endtask

    task automatic check_mac(input mac_addr_t got, input mac_addr_t exp, input string what);
        if (got !== exp) report_fail($sformatf("%s got %012h expected %012h", what, got, exp));
    endtask

    task automatic check_quanta(input pause_quanta_t got, input pause_quanta_t exp,
                                input string what);
        if (got !== exp) report_fail($sformatf("%s got %04h expected %04h", what, got, exp));
    endtask

    task automatic check_fcs(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) report_fail($sformatf("%s got %08h expected %08h", what, got, exp));
    endtask

    // Bit-serial 802.3 CRC taking the LSB of each byte first
    function automatic logic [31:0] crc_serial(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        logic        fb;
        c = crc;
        for (int k = 0; k < 8; k++) begin
            fb = c[0] ^ b[k];
            c  = c >> 1;
            if (fb) c = c ^ `ETH_CRC_POLY;
        end
        return c;
    endfunction

    task automatic build_expected(input pause_quanta_t q, input mac_addr_t m);
        logic [31:0] c;
        logic [47:0] da;
        da = `ETH_PAUSE_DA;
        for (int i = 0; i < 7; i++) exp_frame[i] = `ETH_PREAMBLE_BYTE;
        exp_frame[7] = `ETH_SFD_BYTE;
        for (int i = 0; i < 6; i++) begin
            exp_frame[8 + i]  = da[47 - 8*i -: 8];
            exp_frame[14 + i] = m[47 - 8*i -: 8];
        end
        exp_frame[20] = 8'h88;
        exp_frame[21] = 8'h08;
        exp_frame[22] = 8'h00;
        exp_frame[23] = 8'h01;
        exp_frame[24] = q[15:8];
        exp_frame[25] = q[7:0];
        for (int i = 26; i < 68; i++) exp_frame[i] = 8'h00;
        c = `ETH_CRC_RESIDUE_INIT;
        for (int i = 8; i < 68; i++) c = crc_serial(c, exp_frame[i]);
        c = ~c;
        for (int k = 0; k < 4; k++) exp_frame[68 + k] = c[8*k +: 8];
    endtask

    // Raise req, wait for the frame, capture it and check the completion edge
    task automatic send_frame(input logic [95:0] vec);
        int          lead;
        int          len;
        logic [31:0] res;
        pause_time = vec[95:80];
        local_mac  = vec[79:32];
        req        = 1'b1;
        lead       = 0;
        do begin
            tick();
            lead++;
        end while (!tx_en && lead < LEAD_LIMIT);
        if (!tx_en) begin
            error_count++;
            $display("Handshake timeout: tx_en never rose after the request");
            return;
        end
        if (lead != 3) report_fail($sformatf("tx_en rose %0d edges after req", lead - 1));
        len = 0;
        while (tx_en && len < `ETH_FRAME_BYTES + 8) begin
            if (len < `ETH_FRAME_BYTES) got_frame[len] = tx_data;
            if (ack || frame_complete) report_fail("ack or frame_complete high inside frame");
            len++;
            tick();
        end
        if (len != `ETH_FRAME_BYTES) report_fail($sformatf("tx_en high for %0d cycles", len));
        if (!frame_complete || !ack) report_fail("frame_complete and ack not high after frame");
        build_expected(vec[95:80], vec[79:32]);
        for (int i = 0; i < `ETH_FRAME_BYTES; i++) begin
            check_byte(got_frame[i], exp_frame[i], $sformatf("byte %0d", i));
        end
        check_mac({got_frame[14], got_frame[15], got_frame[16], got_frame[17],
                   got_frame[18], got_frame[19]}, vec[79:32], "source address");
        check_quanta({got_frame[24], got_frame[25]}, vec[95:80], "pause time");
        check_fcs({got_frame[71], got_frame[70], got_frame[69], got_frame[68]},
                  {exp_frame[71], exp_frame[70], exp_frame[69], exp_frame[68]}, "FCS");
        res = `ETH_CRC_RESIDUE_INIT;
        for (int i = 8; i < `ETH_FRAME_BYTES; i++) res = crc_serial(res, got_frame[i]);
        check_fcs(res, vec[31:0], "CRC residue");
        tick();
        if (frame_complete || !ack) report_fail("frame_complete not a single pulse or ack dropped");
    endtask

    task automatic release_req();
        req = 1'b0;
        if (!ack) report_fail("ack low before req dropped");
        tick();
        if (ack) report_fail("ack still high one cycle after req dropped");
    endtask

    task automatic end_test(input string name);
        if (error_count == test_start_errs) begin
            $display("Test %s: passed", name);
        end else begin
            failed_tests++;
            $display("Test %s: failed with %0d errors", name, error_count - test_start_errs);
        end
    endtask

    initial begin
        int gap;
        reset        = 1'b1;
        req          = 1'b0;
        pause_time   = '0;
        local_mac    = '0;
        seed         = 76;
        error_count  = 0;
        failed_tests = 0;
        $readmemh("dv/pause_golden.txt", golden);

        test_start_errs = error_count;
        repeat (2) @(posedge clk);
        #1;
        // Values still held by reset, before any clock edge can load them
        if (tx_en !== 1'b0 || frame_complete !== 1'b0 || ack !== 1'b0 ||
            tx_data !== 8'h00) begin
            report_fail("outputs not cleared by reset");
        end
        reset = 1'b0;
        tick();
        if (tx_en || frame_complete || ack || tx_data !== 8'h00) report_fail("outputs after reset");
        end_test("reset");

        for (int v = 0; v < NUM_VECTORS; v++) begin
            test_start_errs = error_count;
            send_frame(golden[v]);
            release_req();
            tick();
            end_test($sformatf("vector %0d", v));
        end

        // Hold req past ack and expect no second frame
        test_start_errs = error_count;
        gap = 3 + ($unsigned($random(seed)) % 18);
        send_frame(golden[1]);
        repeat (gap) begin
            tick();
            if (tx_en || frame_complete || !ack) report_fail("activity while req held after ack");
        end
        release_req();
        send_frame(golden[2]);
        release_req();
        end_test($sformatf("back-pressure gap %0d", gap));

        $display("Tests run %0d, tests failed %0d, errors %0d",
                 NUM_TESTS, failed_tests, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/pause_golden.txt
// Columns: pause_time (4 hex) local_mac (12 hex) crc_residue (8 hex)
// Residue is the CRC register after the body and its FCS
FFFF001122334455DEBB20E3
0000020000000001DEBB20E3
00010A1B2C3D4E5FDEBB20E3
8000FFFFFFFFFFFEDEBB20E3
1234AABBCCDDEEFFDEBB20E3
00FF5254001234A6DEBB20E3
ABCD000000000000DEBB20E3
7FFF3C970E5D2B11DEBB20E3

// File: include/eth_pause_consts.svh
// Frame constants and field lengths for the 802.3x PAUSE transmitter
`ifndef ETH_PAUSE_CONSTS_SVH
`define ETH_PAUSE_CONSTS_SVH

// Reserved multicast destination for MAC control frames
`define ETH_PAUSE_DA          48'h0180_C200_0001
`define ETH_MAC_CTRL_TYPE     16'h8808
`define ETH_PAUSE_OPCODE      16'h0001

// Preamble and start-of-frame delimiter
`define ETH_PREAMBLE_BYTE     8'h55
`define ETH_SFD_BYTE          8'hD5

// Field lengths in bytes
`define ETH_PREAMBLE_LEN      7
`define ETH_ADDR_BYTES        6
`define ETH_WORD16_BYTES      2
`define ETH_PAD_LEN           42
`define ETH_FCS_BYTES         4
`define ETH_FRAME_BYTES       72

// CRC-32 in reflected form
`define ETH_CRC_POLY          32'hEDB8_8320
`define ETH_CRC_RESIDUE_INIT  32'hFFFF_FFFF

`endif

// File: logic/eth_crc32.sv
// Byte-wide reflected CRC-32 accumulator for the Ethernet FCS
`timescale 1ns/1ps
`default_nettype none
`include "eth_pause_consts.svh"

module eth_crc32 (
    input  logic        clk,
    input  logic        reset,
    input  logic        crc_init,
    input  logic        crc_en,
    input  logic [7:0]  data,
    output logic [31:0] crc_next
);

    logic [31:0] crc_q;

    // Fold one byte into the remainder, LSB first
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] d);
        logic [31:0] c;
        c = crc ^ {24'h0, d};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ `ETH_CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // Remainder including the byte now on the line
    assign crc_next = crc_byte(crc_q, data);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            crc_q <= `ETH_CRC_RESIDUE_INIT;
        end else if (crc_init) begin
            crc_q <= `ETH_CRC_RESIDUE_INIT;
        end else if (crc_en) begin
            crc_q <= crc_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/eth_pause_pkg.sv
// Types shared by the PAUSE transmitter: address, quanta, sequencer state, field select
`default_nettype none

package eth_pause_pkg;

    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] pause_quanta_t;

    // Sequencer state, one-hot
    typedef enum logic [10:0] {
        ST_IDLE     = 11'b000_0000_0001,
        ST_PREAMBLE = 11'b000_0000_0010,
        ST_SFD      = 11'b000_0000_0100,
        ST_DST      = 11'b000_0000_1000,
        ST_SRC      = 11'b000_0001_0000,
        ST_TYPE     = 11'b000_0010_0000,
        ST_OPCODE   = 11'b000_0100_0000,
        ST_QUANTA   = 11'b000_1000_0000,
        ST_PAD      = 11'b001_0000_0000,
        ST_FCS      = 11'b010_0000_0000,
        ST_DONE     = 11'b100_0000_0000
    } tx_state_t;

    // Byte source for the field mux
    typedef enum logic [3:0] {
        SEL_NONE,
        SEL_PREAMBLE,
        SEL_SFD,
        SEL_DST,
        SEL_SRC,
        SEL_TYPE,
        SEL_OPCODE,
        SEL_QUANTA,
        SEL_PAD,
        SEL_FCS
    } field_sel_t;

endpackage

`default_nettype wire

// File: logic/eth_pause_tx_top.sv
// Top level of the PAUSE transmitter: request port, sequencer, field mux and CRC
`timescale 1ns/1ps
`default_nettype none

module eth_pause_tx_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          req,
    input  eth_pause_pkg::pause_quanta_t  pause_time,
    input  eth_pause_pkg::mac_addr_t      local_mac,
    output logic                          ack,
    output logic [7:0]                    tx_data,
    output logic                          tx_en,
    output logic                          frame_complete
);
    import eth_pause_pkg::*;

    logic          busy;
    logic          start;
    pause_quanta_t quanta_q;
    mac_addr_t     mac_q;
    field_sel_t    field_sel;
    logic [5:0]    byte_idx;
    logic          tx_en_next;
    logic          crc_init;
    logic          crc_en;
    logic          frame_done;
    logic [31:0]   crc_next;

    assign frame_complete = frame_done;

    pause_req_port u_req_port (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .pause_time (pause_time),
        .local_mac  (local_mac),
        .busy       (busy),
        .frame_done (frame_done),
        .ack        (ack),
        .start      (start),
        .quanta_q   (quanta_q),
        .mac_q      (mac_q)
    );

    pause_tx_ctrl u_tx_ctrl (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .busy       (busy),
        .field_sel  (field_sel),
        .byte_idx   (byte_idx),
        .tx_en_next (tx_en_next),
        .crc_init   (crc_init),
        .crc_en     (crc_en),
        .frame_done (frame_done)
    );

    pause_field_mux u_field_mux (
        .clk        (clk),
        .reset      (reset),
        .field_sel  (field_sel),
        .byte_idx   (byte_idx),
        .tx_en_next (tx_en_next),
        .quanta_q   (quanta_q),
        .mac_q      (mac_q),
        .crc_next   (crc_next),
        .tx_data    (tx_data),
        .tx_en      (tx_en)
    );

    // CRC watches the transmitted byte stream
    eth_crc32 u_crc32 (
        .clk      (clk),
        .reset    (reset),
        .crc_init (crc_init),
        .crc_en   (crc_en),
        .data     (tx_data),
        .crc_next (crc_next)
    );

endmodule

`default_nettype wire

// File: logic/pause_field_mux.sv
// Registered byte selector that assembles each PAUSE frame byte and the FCS
`timescale 1ns/1ps
`default_nettype none
`include "eth_pause_consts.svh"

module pause_field_mux (
    input  logic                          clk,
    input  logic                          reset,
    input  eth_pause_pkg::field_sel_t     field_sel,
    input  logic [5:0]                    byte_idx,
    input  logic                          tx_en_next,
    input  eth_pause_pkg::pause_quanta_t  quanta_q,
    input  eth_pause_pkg::mac_addr_t      mac_q,
    input  logic [31:0]                   crc_next,
    output logic [7:0]                    tx_data,
    output logic                          tx_en
);
    import eth_pause_pkg::*;

    logic [31:0] fcs_word;
    logic [31:0] fcs_final;
    logic [7:0]  byte_sel;

    // Address bytes go out most significant first
    function automatic logic [7:0] addr_byte(input mac_addr_t addr, input logic [2:0] idx);
        logic [47:0] shifted;
        shifted = addr << (8 * idx);
        return shifted[47:40];
    endfunction

    function automatic logic [7:0] word_byte(input logic [15:0] word, input logic idx);
        return idx ? word[7:0] : word[15:8];
    endfunction

    assign fcs_final = ~crc_next;

    always_comb begin
        case (field_sel)
            SEL_PREAMBLE: byte_sel = `ETH_PREAMBLE_BYTE;
            SEL_SFD:      byte_sel = `ETH_SFD_BYTE;
            SEL_DST:      byte_sel = addr_byte(`ETH_PAUSE_DA, byte_idx[2:0]);
            SEL_SRC:      byte_sel = addr_byte(mac_q, byte_idx[2:0]);
            SEL_TYPE:     byte_sel = word_byte(`ETH_MAC_CTRL_TYPE, byte_idx[0]);
            SEL_OPCODE:   byte_sel = word_byte(`ETH_PAUSE_OPCODE, byte_idx[0]);
            SEL_QUANTA:   byte_sel = word_byte(quanta_q, byte_idx[0]);
            SEL_FCS:      byte_sel = (byte_idx == 6'd0) ? fcs_final[7:0] : fcs_word[7:0];
            default:      byte_sel = 8'h00;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tx_data <= 8'h00;
            tx_en   <= 1'b0;
        end else begin
            tx_data <= byte_sel;
            tx_en   <= tx_en_next;
        end
    end

    // FCS word, low byte first: load the rest on the first select, then shift
    always_ff @(posedge clk) begin
        if (field_sel == SEL_FCS) begin
            fcs_word <= (byte_idx == 6'd0) ? (fcs_final >> 8) : (fcs_word >> 8);
        end
    end

    // A frame only ends after the last FCS byte
    a_tx_en_whole_frame: assert property (@(posedge clk) disable iff (reset)
        (tx_en && !tx_en_next) |->
            ($past(field_sel) == SEL_FCS) && ($past(byte_idx) == 6'(`ETH_FCS_BYTES - 1)));

endmodule

`default_nettype wire

// File: logic/pause_req_port.sv
// Four-phase req/ack responder that captures the PAUSE request fields
`timescale 1ns/1ps
`default_nettype none

module pause_req_port (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          req,
    input  eth_pause_pkg::pause_quanta_t  pause_time,
    input  eth_pause_pkg::mac_addr_t      local_mac,
    input  logic                          busy,
    input  logic                          frame_done,
    output logic                          ack,
    output logic                          start,
    output eth_pause_pkg::pause_quanta_t  quanta_q,
    output eth_pause_pkg::mac_addr_t      mac_q
);
    import eth_pause_pkg::*;

    typedef enum logic [1:0] {
        PORT_WAIT,
        PORT_SERVING,
        PORT_ACKED
    } port_state_t;

    port_state_t port_state;
    logic        accept;

    // Take a new request only when idle on both sides
    assign accept = (port_state == PORT_WAIT) && req && !busy;

    // ack comes up on the same edge as frame_done, then holds from the state
    assign ack = (port_state == PORT_ACKED) || ((port_state == PORT_SERVING) && frame_done);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            port_state <= PORT_WAIT;
            start      <= 1'b0;
        end else begin
            start <= accept;
            case (port_state)
                PORT_WAIT:    if (accept) port_state <= PORT_SERVING;
                PORT_SERVING: if (frame_done) port_state <= PORT_ACKED;
                PORT_ACKED:   if (!req) port_state <= PORT_WAIT;
                default:      port_state <= PORT_WAIT;
            endcase
        end
    end

    // Request fields stay stable until ack, so capture once
    always_ff @(posedge clk) begin
        if (accept) begin
            quanta_q <= pause_time;
            mac_q    <= local_mac;
        end
    end

    a_ack_needs_req: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> req);

endmodule

`default_nettype wire

// File: logic/pause_tx_ctrl.sv
// PAUSE frame sequencer: walks the fields, drives byte selects and CRC controls
`timescale 1ns/1ps
`default_nettype none
`include "eth_pause_consts.svh"

module pause_tx_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    output logic                       busy,
    output eth_pause_pkg::field_sel_t  field_sel,
    output logic [5:0]                 byte_idx,
    output logic                       tx_en_next,
    output logic                       crc_init,
    output logic                       crc_en,
    output logic                       frame_done
);
    import eth_pause_pkg::*;

    tx_state_t  state;
    tx_state_t  state_nxt;
    logic [5:0] byte_cnt;
    logic [5:0] field_len;
    logic       field_last;
    logic       in_body;

    // Length of the field being issued
    always_comb begin
        case (state)
            ST_PREAMBLE: field_len = 6'(`ETH_PREAMBLE_LEN);
            ST_DST,
            ST_SRC:      field_len = 6'(`ETH_ADDR_BYTES);
            ST_TYPE,
            ST_OPCODE,
            ST_QUANTA:   field_len = 6'(`ETH_WORD16_BYTES);
            ST_PAD:      field_len = 6'(`ETH_PAD_LEN);
            ST_FCS:      field_len = 6'(`ETH_FCS_BYTES);
            default:     field_len = 6'd1;
        endcase
    end

    assign field_last = (byte_cnt == field_len - 6'd1);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:     if (start) state_nxt = ST_PREAMBLE;
            ST_PREAMBLE: if (field_last) state_nxt = ST_SFD;
            ST_SFD:      state_nxt = ST_DST;
            ST_DST:      if (field_last) state_nxt = ST_SRC;
            ST_SRC:      if (field_last) state_nxt = ST_TYPE;
            ST_TYPE:     if (field_last) state_nxt = ST_OPCODE;
            ST_OPCODE:   if (field_last) state_nxt = ST_QUANTA;
            ST_QUANTA:   if (field_last) state_nxt = ST_PAD;
            ST_PAD:      if (field_last) state_nxt = ST_FCS;
            ST_FCS:      if (field_last) state_nxt = ST_DONE;
            ST_DONE:     state_nxt = ST_IDLE;
            default:     state_nxt = ST_IDLE;
        endcase
    end

    // Select for the byte that goes out on the next edge
    always_comb begin
        case (state)
            ST_PREAMBLE: field_sel = SEL_PREAMBLE;
            ST_SFD:      field_sel = SEL_SFD;
            ST_DST:      field_sel = SEL_DST;
            ST_SRC:      field_sel = SEL_SRC;
            ST_TYPE:     field_sel = SEL_TYPE;
            ST_OPCODE:   field_sel = SEL_OPCODE;
            ST_QUANTA:   field_sel = SEL_QUANTA;
            ST_PAD:      field_sel = SEL_PAD;
            ST_FCS:      field_sel = SEL_FCS;
            default:     field_sel = SEL_NONE;
        endcase
    end

    // Destination address through pad are covered by the FCS
    assign in_body = (state == ST_DST) || (state == ST_SRC) || (state == ST_TYPE) ||
                     (state == ST_OPCODE) || (state == ST_QUANTA) || (state == ST_PAD);

    assign busy       = (state != ST_IDLE);
    assign byte_idx   = byte_cnt;
    assign tx_en_next = (state != ST_IDLE) && (state != ST_DONE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= ST_IDLE;
            byte_cnt <= 6'd0;
        end else begin
            state <= state_nxt;
            if (field_last || state == ST_IDLE || state == ST_DONE) begin
                byte_cnt <= 6'd0;
            end else begin
                byte_cnt <= byte_cnt + 6'd1;
            end
        end
    end

    // CRC controls lag the selects by one cycle to line up with tx_data
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            crc_init   <= 1'b0;
            crc_en     <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            crc_init   <= (state == ST_SFD);
            crc_en     <= in_body;
            frame_done <= (state == ST_DONE);
        end
    end

    a_state_onehot: assert property (@(posedge clk) disable iff (reset) $onehot(state));
    a_no_start_busy: assert property (@(posedge clk) disable iff (reset) start |-> !busy);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the PAUSE transmitter testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -f vlog.f \
    --top-module eth_pause_tx_tb -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "Everything OK" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation did not pass"; exit 1; }

// File: vlog.f
+incdir+include
logic/eth_pause_pkg.sv
logic/pause_req_port.sv
logic/pause_tx_ctrl.sv
logic/pause_field_mux.sv
logic/eth_crc32.sv
logic/eth_pause_tx_top.sv
dv/eth_pause_tx_tb.sv
